// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mem_stage
FILELIST = build.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+.
mips_mem_pkg.sv
mem_access.sv
ll_link.sv
mem_wait_timer.sv
mem_stall_fsm.sv
data_sram.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== data_sram.sv ====
`include "mips_mem_consts.svh"

module data_sram (
    input  logic                   clk,
    input  logic                   fire,
    input  mips_mem_pkg::byte_en_t wen,
    input  mips_mem_pkg::addr_t    addr,
    input  mips_mem_pkg::word_t    wdata,
    output mips_mem_pkg::word_t    rdata
);
    import mips_mem_pkg::*;

    localparam int DEPTH = 1 << `DSRAM_AW;

    word_t                mem [DEPTH];
    logic [`DSRAM_AW-1:0] idx;

    // byte address to word index, upper bits alias
    assign idx = addr[`DSRAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (fire) begin
            // read-before-write, rdata holds the old word
            rdata <= mem[idx];
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== ll_link.sv ====
`include "mips_mem_consts.svh"

module ll_link (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  done,
    input  mips_mem_pkg::mem_op_t op,
    output logic                  ll_bit
);

    // sampled only when an access retires so SC sees a stable bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ll_bit <= 1'b0;
        end else if (done) begin
            if (op == `OP_LL) begin
                ll_bit <= 1'b1;
            end else if (op == `OP_SC) begin
                // any SC consumes the link, pass or fail
                ll_bit <= 1'b0;
            end
        end
    end

    a_ll_rise_on_ll_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ll_bit) |-> $past(done && (op == `OP_LL))
    ) else $error("ll_link: link bit set without a completed LL");

endmodule

// ==== mem_access.sv ====
`include "mips_mem_consts.svh"

module mem_access (
    input  logic                      mem_en,
    input  mips_mem_pkg::mem_op_t     mem_op,
    input  mips_mem_pkg::word_t       mem_wdata,
    input  mips_mem_pkg::addr_t       mem_addr,
    output mips_mem_pkg::word_t       mem_rdata,

    input  logic                      master_mem_sel,
    input  logic                      slave_mem_sel,
    input  mips_mem_pkg::except_bus_t master_except,
    input  mips_mem_pkg::except_bus_t slave_except,

    input  mips_mem_pkg::word_t       sram_rdata,
    input  logic                      ll_bit,
    output logic                      access_req,
    output mips_mem_pkg::addr_t       sram_addr,
    output mips_mem_pkg::word_t       sram_wdata,
    output mips_mem_pkg::byte_en_t    sram_wen,
    output mips_mem_pkg::rlen_t       sram_rlen
);
    import mips_mem_pkg::*;

    logic [1:0]  ofs;
    logic        half_ok;
    logic        word_ok;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    byte_en_t    byte_lane;
    logic        is_load;

    // slave slot only goes if the older master slot did not trap
    assign access_req = mem_en &&
                        ((master_mem_sel && ~(|master_except)) ||
                         (slave_mem_sel && ~(|master_except) && ~(|slave_except)));
    assign sram_addr  = mem_addr;

    assign ofs       = mem_addr[1:0];
    assign half_ok   = (ofs[0] == 1'b0);
    assign word_ok   = (ofs == 2'b00);
    assign rd_byte   = sram_rdata[ofs*8 +: 8];
    assign rd_half   = ofs[1] ? sram_rdata[31:16] : sram_rdata[15:0];
    assign byte_lane = byte_en_t'(4'b0001 << ofs);

    // loads sit in the 100xxx and 110xxx opcode rows
    assign is_load   = mem_op[5] & ~mem_op[3];

    always_comb begin
        sram_wen   = 4'b0000;
        sram_wdata = '0;
        sram_rlen  = 2'd0;
        mem_rdata  = '0;
        case (mem_op)
            `OP_LW, `OP_LL: begin
                sram_rlen = 2'd2;
                mem_rdata = word_ok ? sram_rdata : '0;
            end
            `OP_LH: begin
                sram_rlen = 2'd1;
                mem_rdata = half_ok ? {{16{rd_half[15]}}, rd_half} : '0;
            end
            `OP_LHU: begin
                sram_rlen = 2'd1;
                mem_rdata = half_ok ? {16'h0000, rd_half} : '0;
            end
            `OP_LB: begin
                mem_rdata = {{24{rd_byte[7]}}, rd_byte};
            end
            `OP_LBU: begin
                mem_rdata = {24'h000000, rd_byte};
            end
            `OP_SW: begin
                sram_wen   = {4{word_ok}};
                sram_wdata = mem_wdata;
            end
            `OP_SC: begin
                // store only lands while the link holds, rt gets the outcome
                sram_wen   = {4{word_ok & ll_bit}};
                sram_wdata = mem_wdata;
                mem_rdata  = {31'b0, ll_bit};
            end
            `OP_SH: begin
                sram_wen   = half_ok ? (ofs[1] ? 4'b1100 : 4'b0011) : 4'b0000;
                sram_wdata = {2{mem_wdata[15:0]}};
            end
            `OP_SB: begin
                sram_wen   = byte_lane;
                sram_wdata = {4{mem_wdata[7:0]}};
            end
            default: ;
        endcase
    end

    always_comb begin
        if (is_load) begin
            assert (sram_wen == 4'b0000)
                else $error("mem_access: byte enables %b on load op %h", sram_wen, mem_op);
        end
    end

endmodule

// ==== mem_stage_top.sv ====
module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_en,
    input  mips_mem_pkg::mem_op_t     mem_op,
    input  mips_mem_pkg::word_t       mem_wdata,
    input  mips_mem_pkg::addr_t       mem_addr,
    input  logic                      master_mem_sel,
    input  logic                      slave_mem_sel,
    input  mips_mem_pkg::except_bus_t master_except,
    input  mips_mem_pkg::except_bus_t slave_except,
    output mips_mem_pkg::word_t       mem_rdata,
    output logic                      mem_stall,
    output logic                      mem_done
);
    import mips_mem_pkg::*;

    logic     access_req;
    logic     ll_bit;
    logic     timer_start;
    logic     timer_done;
    logic     sram_fire;
    addr_t    sram_addr;
    word_t    sram_wdata;
    word_t    sram_rdata;
    byte_en_t sram_wen;

    // rlen has no consumer on this word-wide SRAM
    mem_access u_mem_access (
        .mem_en         (mem_en),
        .mem_op         (mem_op),
        .mem_wdata      (mem_wdata),
        .mem_addr       (mem_addr),
        .mem_rdata      (mem_rdata),
        .master_mem_sel (master_mem_sel),
        .slave_mem_sel  (slave_mem_sel),
        .master_except  (master_except),
        .slave_except   (slave_except),
        .sram_rdata     (sram_rdata),
        .ll_bit         (ll_bit),
        .access_req     (access_req),
        .sram_addr      (sram_addr),
        .sram_wdata     (sram_wdata),
        .sram_wen       (sram_wen),
        .sram_rlen      ()
    );

    mem_stall_fsm u_mem_stall_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .access_req  (access_req),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .sram_fire   (sram_fire),
        .mem_stall   (mem_stall),
        .mem_done    (mem_done)
    );

    mem_wait_timer u_mem_wait_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .fire  (sram_fire),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    ll_link u_ll_link (
        .clk    (clk),
        .rst_n  (rst_n),
        .done   (mem_done),
        .op     (mem_op),
        .ll_bit (ll_bit)
    );

endmodule

// ==== mem_stall_fsm.sv ====
module mem_stall_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic access_req,
    input  logic timer_done,
    output logic timer_start,
    output logic sram_fire,
    output logic mem_stall,
    output logic mem_done
);
    import mips_mem_pkg::*;

    mem_state_e state;
    mem_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        timer_start = 1'b0;
        sram_fire   = 1'b0;
        mem_stall   = 1'b0;
        mem_done    = 1'b0;
        case (state)
            IDLE: begin
                // stall the pipe in the very cycle the request shows up
                mem_stall   = access_req;
                timer_start = access_req;
                if (access_req) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                mem_stall = 1'b1;
                if (timer_done) begin
                    state_next = ACCESS;
                end
            end
            ACCESS: begin
                mem_stall  = 1'b1;
                sram_fire  = 1'b1;
                state_next = RESP;
            end
            RESP: begin
                // read data is in the SRAM output register now
                mem_done   = 1'b1;
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    a_done_then_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_done |=> (state == IDLE)
    ) else $error("mem_stall_fsm: not idle after mem_done");

endmodule

// ==== mem_wait_timer.sv ====
`include "mips_mem_consts.svh"

module mem_wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int CNT_W = $clog2(`MEM_WAIT_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic             busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`MEM_WAIT_CYCLES - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // last wait cycle
    assign done = busy && (cnt == '0);

    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    ) else $error("mem_wait_timer: start while a count is running");

endmodule

// ==== mips_mem_consts.svh ====
`ifndef MIPS_MEM_CONSTS_SVH
`define MIPS_MEM_CONSTS_SVH

// primary opcode field of the MIPS load/store instructions
`define OP_LB           6'b100000
`define OP_LH           6'b100001
`define OP_LW           6'b100011
`define OP_LBU          6'b100100
`define OP_LHU          6'b100101
`define OP_SB           6'b101000
`define OP_SH           6'b101001
`define OP_SW           6'b101011
`define OP_LL           6'b110000
`define OP_SC           6'b111000

// exception bus of one issue slot, nonzero means excepted
`define EXCEPT_W        8

// bus wait states before the SRAM cycle, at least 1
`define MEM_WAIT_CYCLES 2

// word-address width, 256 words
`define DSRAM_AW        8

`endif

// ==== mips_mem_pkg.sv ====
`include "mips_mem_consts.svh"

package mips_mem_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    typedef logic [5:0] mem_op_t;

    // one enable per byte lane, bit 0 is bits 7:0
    typedef logic [3:0] byte_en_t;

    // 0: 1 byte, 1: 2 bytes, 2: 4 bytes
    typedef logic [1:0] rlen_t;

    typedef logic [`EXCEPT_W-1:0] except_bus_t;

    // access sequencing
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACCESS,
        RESP
    } mem_state_e;

endpackage

// ==== tb_mem_stage.sv ====
`include "mips_mem_consts.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_mem_pkg::*;

    localparam int N_TESTS = 64;
    localparam int LAT = `MEM_WAIT_CYCLES + 2;

    logic        clk;
    logic        rst_n;
    logic        mem_en;
    logic        master_mem_sel;
    logic        slave_mem_sel;
    logic        mem_stall;
    logic        mem_done;
    mem_op_t     mem_op;
    word_t       mem_wdata;
    word_t       mem_rdata;
    addr_t       mem_addr;
    except_bus_t master_except;
    except_bus_t slave_except;

    // shadow model of the SRAM and the link bit
    word_t       shadow [256];
    logic        shadow_ll;
    word_t       exp_rdata;
    string       exp_name;
    logic        expect_done;
    int          n_tests;
    int          err_count;

    mem_stage_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t ref_access(mem_op_t op, addr_t addr, word_t wdata, word_t w,
                                         logic ll);
        logic [7:0]  b;
        logic [15:0] h;
        case (addr[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = addr[1] ? w[31:16] : w[15:0];
        case (op)
            `OP_LW, `OP_LL: return (addr[1:0] == 2'b00) ? w : 32'h0;
            `OP_LB: return {{24{b[7]}}, b};
            `OP_LBU: return {24'h0, b};
            // odd halfword address reads as zero
            `OP_LH: return addr[0] ? 32'h0 : {{16{h[15]}}, h};
            `OP_LHU: return addr[0] ? 32'h0 : {16'h0, h};
            `OP_SC: return {31'h0, ll};
            default: return 32'h0;
        endcase
    endfunction

    function automatic word_t apply_store(mem_op_t op, addr_t addr, word_t wdata, word_t w,
                                          logic ll);
        word_t r;
        r = w;
        case (op)
            `OP_SW: if (addr[1:0] == 2'b00) r = wdata;
            `OP_SC: if (addr[1:0] == 2'b00 && ll) r = wdata;
            `OP_SH: if (!addr[0]) r[16*addr[1] +: 16] = wdata[15:0];
            `OP_SB: r[8*addr[1:0] +: 8] = wdata[7:0];
            default: ;
        endcase
        return r;
    endfunction

    // read data check in the completion cycle
    always @(negedge clk) begin
        if (rst_n && mem_done && expect_done) begin
            if (mem_rdata !== exp_rdata) begin
                $display("ERR %s: expected %h actual %h", exp_name, exp_rdata, mem_rdata);
                err_count++;
            end
        end
    end

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s bad", name);
        end
    endtask

    task automatic run_access(input string name, input mem_op_t op, input addr_t addr,
                              input word_t wdata, input logic use_slave);
        int    cycles;
        int    errs_before;
        word_t new_word;
        errs_before = err_count;
        exp_rdata = ref_access(op, addr, wdata, shadow[addr[9:2]], shadow_ll);
        new_word = apply_store(op, addr, wdata, shadow[addr[9:2]], shadow_ll);
        exp_name = name;
        expect_done = 1'b1;
        mem_en = 1'b1;
        mem_op = op;
        mem_addr = addr;
        mem_wdata = wdata;
        master_mem_sel = !use_slave;
        slave_mem_sel = use_slave;
        cycles = 0;
        #1;
        while (!mem_done && cycles < 4 * LAT) begin
            if (!mem_stall) begin
                $display("%s: mem_stall low before mem_done in cycle %0d", name, cycles);
                err_count++;
            end
            @(negedge clk);
            cycles++;
        end
        if (!mem_done) begin
            $display("%s: no mem_done within %0d cycles", name, 4 * LAT);
            err_count++;
        end else begin
            if (cycles != LAT) begin
                $display("ERR %s latency: expected %0d actual %0d", name, LAT, cycles);
                err_count++;
            end
            if (mem_stall) begin
                $display("%s: mem_stall still high in the mem_done cycle", name);
                err_count++;
            end
            shadow[addr[9:2]] = new_word;
            if (op == `OP_LL) begin
                shadow_ll = 1'b1;
            end else if (op == `OP_SC) begin
                shadow_ll = 1'b0;
            end
        end
        @(negedge clk);
        mem_en = 1'b0;
        expect_done = 1'b0;
        n_tests++;
        report_test(name, errs_before);
    endtask

    // store that must be dropped by the slot gating
    task automatic run_blocked(input string name, input logic en, input logic m_sel,
                               input logic s_sel, input except_bus_t m_exc,
                               input except_bus_t s_exc, input addr_t addr);
        int errs_before;
        errs_before = err_count;
        mem_en = en;
        master_mem_sel = m_sel;
        slave_mem_sel = s_sel;
        master_except = m_exc;
        slave_except = s_exc;
        mem_op = `OP_SW;
        mem_addr = addr;
        mem_wdata = ~shadow[addr[9:2]];
        #1;
        for (int i = 0; i < 6; i++) begin
            if (mem_done || mem_stall) begin
                $display("%s: gated access raised mem_done or mem_stall", name);
                err_count++;
            end
            @(negedge clk);
        end
        mem_en = 1'b0;
        master_mem_sel = 1'b0;
        slave_mem_sel = 1'b0;
        master_except = '0;
        slave_except = '0;
        n_tests++;
        report_test(name, errs_before);
    endtask

    initial begin
        word_t w;
        rst_n = 1'b0;
        mem_en = 1'b0;
        mem_op = '0;
        mem_wdata = '0;
        mem_addr = '0;
        master_mem_sel = 1'b0;
        slave_mem_sel = 1'b0;
        master_except = '0;
        slave_except = '0;
        shadow_ll = 1'b0;
        expect_done = 1'b0;
        n_tests = 0;
        err_count = 0;
        void'($urandom(32'h5630_96a7));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // lanes 0 and 3 negative, lanes 1 and 2 positive
        w = ($urandom() & 32'h7f7f_7f7f) | 32'h8000_0080;
        run_access("sw_rand", `OP_SW, 32'h40, w, 1'b0);
        for (int i = 0; i < 4; i++) begin
            run_access($sformatf("lb_%0d", i), `OP_LB, 32'h40 + i, 32'h0, 1'b0);
            run_access($sformatf("lbu_%0d", i), `OP_LBU, 32'h40 + i, 32'h0, 1'b0);
            if ((i % 2) == 0) begin
                run_access($sformatf("lh_%0d", i), `OP_LH, 32'h40 + i, 32'h0, 1'b0);
                run_access($sformatf("lhu_%0d", i), `OP_LHU, 32'h40 + i, 32'h0, 1'b0);
            end
        end

        for (int i = 0; i < 4; i++) begin
            run_access("sw_base", `OP_SW, 32'h80, 32'h1122_3344, 1'b0);
            run_access($sformatf("sb_%0d", i), `OP_SB, 32'h80 + i, 32'h0000_00a5 + i, 1'b1);
            run_access($sformatf("lw_sb_%0d", i), `OP_LW, 32'h80, 32'h0, 1'b0);
        end
        for (int i = 0; i < 4; i += 2) begin
            run_access("sw_base", `OP_SW, 32'h84, 32'h5566_7788, 1'b0);
            run_access($sformatf("sh_%0d", i), `OP_SH, 32'h84 + i, 32'h0000_beef ^ i, 1'b0);
            run_access($sformatf("lw_sh_%0d", i), `OP_LW, 32'h84, 32'h0, 1'b1);
        end

        run_access("sw_link", `OP_SW, 32'hc0, 32'h0bad_f00d, 1'b0);
        run_access("ll", `OP_LL, 32'hc0, 32'h0, 1'b0);
        run_access("sc_ok", `OP_SC, 32'hc0, 32'h600d_c0de, 1'b0);
        run_access("lw_sc_ok", `OP_LW, 32'hc0, 32'h0, 1'b0);
        run_access("sc_fail", `OP_SC, 32'hc0, 32'hdead_beef, 1'b0);
        run_access("lw_sc_fail", `OP_LW, 32'hc0, 32'h0, 1'b0);

        run_access("sw_gate", `OP_SW, 32'h100, 32'h5a5a_0ff0, 1'b0);
        run_blocked("gate_m_exc", 1'b1, 1'b1, 1'b0, 8'h04, 8'h00, 32'h100);
        run_blocked("gate_s_exc", 1'b1, 1'b0, 1'b1, 8'h00, 8'h80, 32'h100);
        run_blocked("gate_en", 1'b0, 1'b1, 1'b0, 8'h00, 8'h00, 32'h100);
        run_access("lw_gate", `OP_LW, 32'h100, 32'h0, 1'b1);

        run_access("sw_mis_base", `OP_SW, 32'h140, 32'hcafe_babe, 1'b0);
        run_access("sw_mis", `OP_SW, 32'h141, 32'h1234_5678, 1'b0);
        run_access("sh_mis", `OP_SH, 32'h143, 32'h0000_9abc, 1'b0);
        run_access("lw_mis", `OP_LW, 32'h140, 32'h0, 1'b0);
        run_access("lh_mis", `OP_LH, 32'h141, 32'h0, 1'b0);

        $display("tests %0d errors %0d", n_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // budget of 10 cycles per test plus a margin for reset
    initial begin
        #(N_TESTS * 10 * 10 + 1000);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

endmodule
